/* all.f */
+incdir+logic
+incdir+tb
logic/cpu_ctrl_pkg.sv
logic/insn_decode.sv
logic/ctrl_execute.sv
logic/ctrl_result.sv
logic/cpu_ctrl_top.sv
tb/tb_cpu_ctrl.sv

/* logic/cpu_ctrl_cfg.svh */
/*
 * Sizing and fixed indices for the 16-bit sequencing unit.
 * The PC must stay r7 and the flags target r0; the decoder and the
 * control word assume 8 registers with 3-bit indices.
 * The immediate prefix width plus the 4-bit pout_lo field must equal the word width.
 */
`ifndef CPU_CTRL_CFG_SVH
`define CPU_CTRL_CFG_SVH

// instruction and data word
`define CPU_WORD_W 16

// register file
`define CPU_NREGS 8
`define CPU_REG_IDX_W 3

// r7 doubles as program counter
`define CPU_PC_REG 3'd7

// target of the flags copy
`define CPU_FLAGS_REG 3'd0

// alu operation select, 4 bits from the word plus a high bit
`define CPU_ALU_OP_W 5

// upper bits of pout, set by the prefix instruction
`define CPU_IMM_W 12

// NOP is the all-zero word
`define CPU_NOP_WORD 16'h0000

`endif

/* logic/cpu_ctrl_pkg.sv */
/*
 * Types shared by the sequencing unit: instruction formats, classes,
 * pipeline requests and the control word to register file, ALU and memory.
 * All register masks in ctrl_word_t are active low.
 */
`include "cpu_ctrl_cfg.svh"

package cpu_ctrl_pkg;

	typedef enum logic [3:0] {
		CLS_NOP     = 4'h0,
		CLS_IMM     = 4'h1, // 12-bit prefix
		CLS_ALU2    = 4'h2, // reg, reg
		CLS_ALUI    = 4'h3, // reg, imm4
		CLS_BR      = 4'h4, // absolute branch
		CLS_MEM     = 4'h5, // load / store, reg index
		CLS_ALU3    = 4'h8, // 3'b100 prefix
		CLS_FLAGS   = 4'hc, // 3'b110 prefix
		CLS_ILLEGAL = 4'hf
	} insn_class_t;

	typedef union packed {
		logic [`CPU_WORD_W-1:0] word;
		struct packed {
			logic [3:0] cls;
			logic [3:0] op;
			logic       nostore; // compare style, result dropped
			logic [2:0] dst;
			logic [3:0] src_imm; // src in [2:0], op high bit in [3]
		} alu2;
		struct packed {
			logic [2:0] cls;
			logic [3:0] op;
			logic [2:0] dst;
			logic [2:0] src2; // drives alu A
			logic [2:0] src;  // drives alu B
		} alu3;
		struct packed {
			logic [3:0] cls;
			logic       rsvd11;
			logic       post_dec_n;
			logic       post_inc_n;
			logic       store;
			logic       rsvd7;
			logic [2:0] data;
			logic       rsvd3;
			logic [2:0] index;
		} mem;
		struct packed {
			logic [3:0] cls;
			logic       indirect;
			logic [2:0] cond;
			logic       rsvd7;
			logic [2:0] tgt;
			logic [3:0] imm4;
		} br;
	} insn_u;

	typedef struct packed {
		logic        valid; // word came from fetch, not an injected NOP
		insn_class_t cls;
		insn_u       insn;
	} dec_t;

	typedef struct packed {
		logic feed_nop;
		logic stall_next;
		logic delay_next;
	} seq_req_t;

	typedef struct packed {
		logic stall;
		logic delay;
	} seq_state_t;

	typedef struct packed {
		logic [`CPU_ALU_OP_W-1:0]         alu_op;
		logic [`CPU_REG_IDX_W-1:0]        alu_a_sel;
		logic [`CPU_REG_IDX_W-1:0]        alu_b_sel;
		logic                             alu_b_from_p_b; // 0 = B from pout
		logic [`CPU_NREGS-1:0]            ld_alu_b;
		logic [`CPU_NREGS-1:0]            ld_mem_b;
		logic [`CPU_NREGS-1:0]            ld_p_b;
		logic                             m_en_b;
		logic [`CPU_REG_IDX_W-1:0]        m_sel;
		logic [`CPU_REG_IDX_W-1:0]        maddr_sel;
		logic [`CPU_NREGS-1:0]            inc_b;
		logic [`CPU_NREGS-1:0]            dec_b;
		logic                             mem_oe_b;
		logic                             mem_wr_b;
		logic [`CPU_WORD_W-`CPU_IMM_W-1:0] pout_lo;
	} ctrl_word_t;

	// active-low one-register select
	function automatic logic [`CPU_NREGS-1:0] sel_mask(input logic [`CPU_REG_IDX_W-1:0] idx);
		logic [`CPU_NREGS-1:0] m;
		m = '1;
		m[idx] = 1'b0;
		return m;
	endfunction

endpackage

/* logic/cpu_ctrl_top.sv */
/*
 * Sequencing and control unit of the 16-bit core.
 * Outputs are combinational from state; memory_in must hold the word at
 * address r7 whenever maddr_sel is 7 and mem_oe_b is low.
 */
`timescale 1ns/1ps
`include "cpu_ctrl_cfg.svh"

module cpu_ctrl_top (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic [`CPU_WORD_W-1:0]   memory_in,
	input  logic                     c,
	input  logic                     z,
	input  logic                     s,
	output cpu_ctrl_pkg::ctrl_word_t ctrl,
	output logic [`CPU_WORD_W-1:0]   pout
);
	import cpu_ctrl_pkg::*;

	dec_t                  p0;
	dec_t                  p1;
	seq_state_t            seq;
	seq_req_t              req;
	ctrl_word_t            exec_ctrl;
	logic [`CPU_IMM_W-1:0] imm;

	insn_decode u_decode (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.memory_in (memory_in),
		.req       (req),
		.p0        (p0),
		.p1        (p1),
		.seq       (seq),
		.imm       (imm)
	);

	ctrl_execute u_execute (
		.p0        (p0),
		.seq       (seq),
		.c         (c),
		.z         (z),
		.s         (s),
		.exec_ctrl (exec_ctrl),
		.req       (req)
	);

	ctrl_result u_result (
		.exec_ctrl (exec_ctrl),
		.p1        (p1),
		.imm       (imm),
		.ctrl      (ctrl),
		.pout      (pout)
	);

endmodule

/* logic/ctrl_execute.sv */
/*
 * Stage-0 control word and pipeline requests, purely combinational.
 * Fetch through r7 is the default unless a load stall is in progress.
 * Condition 7 never branches here; NOP and illegal words add nothing.
 */
`timescale 1ns/1ps
`include "cpu_ctrl_cfg.svh"

module ctrl_execute (
	input  cpu_ctrl_pkg::dec_t       p0,
	input  cpu_ctrl_pkg::seq_state_t seq,
	input  logic                     c,
	input  logic                     z,
	input  logic                     s,
	output cpu_ctrl_pkg::ctrl_word_t exec_ctrl,
	output cpu_ctrl_pkg::seq_req_t   req
);
	import cpu_ctrl_pkg::*;

	function automatic logic br_taken(input logic [2:0] cond, input logic c_in,
		input logic z_in, input logic s_in);
		logic t;
		case (cond)
			3'd0:    t = z_in;
			3'd1:    t = !z_in;
			3'd2:    t = s_in;
			3'd3:    t = !s_in;
			3'd4:    t = c_in;
			3'd5:    t = !c_in;
			3'd6:    t = 1'b1; // always
			default: t = 1'b0;
		endcase
		return t;
	endfunction

	always_comb begin
		exec_ctrl.alu_op         = '0;
		exec_ctrl.alu_a_sel      = '0;
		exec_ctrl.alu_b_sel      = '0;
		exec_ctrl.alu_b_from_p_b = 1'b1;
		exec_ctrl.ld_alu_b       = '1;
		exec_ctrl.ld_mem_b       = '1;
		exec_ctrl.ld_p_b         = '1;
		exec_ctrl.m_en_b         = 1'b1;
		exec_ctrl.m_sel          = '0;
		exec_ctrl.maddr_sel      = '0;
		exec_ctrl.inc_b          = '1;
		exec_ctrl.dec_b          = '1;
		exec_ctrl.mem_oe_b       = 1'b1;
		exec_ctrl.mem_wr_b       = 1'b1;
		exec_ctrl.pout_lo        = '0;
		req                      = '0;

		// fetch, also during the branch delay cycle
		if (!seq.stall) begin
			exec_ctrl.maddr_sel             = `CPU_PC_REG;
			exec_ctrl.mem_oe_b              = 1'b0;
			exec_ctrl.inc_b[`CPU_PC_REG]    = 1'b0;
		end

		if (p0.valid) begin
			case (p0.cls)
				CLS_ALU2: begin
					exec_ctrl.alu_op    = {p0.insn.alu2.src_imm[3], p0.insn.alu2.op};
					exec_ctrl.alu_a_sel = p0.insn.alu2.dst;
					exec_ctrl.alu_b_sel = p0.insn.alu2.src_imm[2:0];
					if (!p0.insn.alu2.nostore)
						exec_ctrl.ld_alu_b = sel_mask(p0.insn.alu2.dst);
				end
				CLS_ALUI: begin
					exec_ctrl.alu_op         = {1'b0, p0.insn.alu2.op};
					exec_ctrl.alu_a_sel      = p0.insn.alu2.dst;
					exec_ctrl.alu_b_from_p_b = 1'b0; // B = {imm, imm4}
					exec_ctrl.pout_lo        = p0.insn.alu2.src_imm;
					if (!p0.insn.alu2.nostore)
						exec_ctrl.ld_alu_b = sel_mask(p0.insn.alu2.dst);
				end
				CLS_ALU3: begin
					exec_ctrl.alu_op    = {1'b0, p0.insn.alu3.op};
					exec_ctrl.alu_a_sel = p0.insn.alu3.src2;
					exec_ctrl.alu_b_sel = p0.insn.alu3.src;
					exec_ctrl.ld_alu_b  = sel_mask(p0.insn.alu3.dst);
				end
				CLS_BR: begin
					if (br_taken(p0.insn.br.cond, c, z, s)) begin
						req.feed_nop                 = 1'b1; // word behind branch discarded
						req.delay_next               = 1'b1;
						exec_ctrl.inc_b[`CPU_PC_REG] = 1'b1;
						if (p0.insn.br.indirect) begin
							exec_ctrl.alu_op         = `CPU_ALU_OP_W'd1; // tgt + pout
							exec_ctrl.alu_a_sel      = p0.insn.br.tgt;
							exec_ctrl.alu_b_from_p_b = 1'b0;
							exec_ctrl.ld_alu_b       = sel_mask(`CPU_PC_REG);
						end else begin
							exec_ctrl.pout_lo = p0.insn.br.imm4;
							exec_ctrl.ld_p_b  = sel_mask(`CPU_PC_REG); // r7 <= pout
						end
					end
				end
				CLS_MEM: begin
					exec_ctrl.maddr_sel = p0.insn.mem.index; // bus taken from fetch
					req.feed_nop        = 1'b1;
					if (!p0.insn.mem.store) begin
						req.stall_next = 1'b1; // read happens in stage 1
					end else begin
						exec_ctrl.m_en_b   = 1'b0;
						exec_ctrl.m_sel    = p0.insn.mem.data;
						exec_ctrl.mem_oe_b = 1'b1;
						exec_ctrl.mem_wr_b = 1'b0;
						exec_ctrl.inc_b[p0.insn.mem.index] = p0.insn.mem.post_inc_n;
						exec_ctrl.dec_b[p0.insn.mem.index] = p0.insn.mem.post_dec_n;
					end
					exec_ctrl.dec_b[`CPU_PC_REG] = 1'b0; // refetch the skipped word
					exec_ctrl.inc_b[`CPU_PC_REG] = 1'b1;
				end
				CLS_FLAGS: begin
					exec_ctrl.pout_lo = {1'b0, c, z, s};
					exec_ctrl.ld_p_b  = sel_mask(`CPU_FLAGS_REG);
				end
				default: ; // nop, prefix, illegal
			endcase
		end

		// stage 0 is empty while a load stalls
		a_stall_empty: assert (!(seq.stall && p0.valid))
			else $error("valid instruction in stage 0 during a load stall");
	end

endmodule

/* logic/ctrl_result.sv */
/*
 * Stage-1 completion of loads on top of the stage-0 control word.
 * Only loads finish in stage 1; stage 0 holds an injected NOP then,
 * so the overlay never meets a stage-0 memory access.
 */
`timescale 1ns/1ps
`include "cpu_ctrl_cfg.svh"

module ctrl_result (
	input  cpu_ctrl_pkg::ctrl_word_t exec_ctrl,
	input  cpu_ctrl_pkg::dec_t       p1,
	input  logic [`CPU_IMM_W-1:0]    imm,
	output cpu_ctrl_pkg::ctrl_word_t ctrl,
	output logic [`CPU_WORD_W-1:0]   pout
);
	import cpu_ctrl_pkg::*;

	logic load_done;

	always_comb begin
		load_done = p1.valid && p1.cls == CLS_MEM && !p1.insn.mem.store;
		ctrl      = exec_ctrl;

		if (load_done) begin
			ctrl.maddr_sel = p1.insn.mem.index;
			ctrl.mem_oe_b  = 1'b0; // memory drives data bus
			ctrl.mem_wr_b  = 1'b1;
			ctrl.ld_mem_b  = sel_mask(p1.insn.mem.data);
			ctrl.inc_b[p1.insn.mem.index] = p1.insn.mem.post_inc_n;
			ctrl.dec_b[p1.insn.mem.index] = p1.insn.mem.post_dec_n;
		end

		// pipeline constant, prefix on top
		pout = {imm, ctrl.pout_lo};

		a_no_bus_clash: assert (ctrl.mem_oe_b || ctrl.mem_wr_b)
			else $error("memory read and write enabled together");
	end

endmodule

/* logic/insn_decode.sv */
/*
 * Stage registers, stall / delay state and immediate prefix.
 * Requests from execute take effect at the next edge; a prefix only
 * reaches the instruction right behind it, imm clears otherwise.
 */
`timescale 1ns/1ps
`include "cpu_ctrl_cfg.svh"

module insn_decode (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic [`CPU_WORD_W-1:0]   memory_in,
	input  cpu_ctrl_pkg::seq_req_t   req,
	output cpu_ctrl_pkg::dec_t       p0,
	output cpu_ctrl_pkg::dec_t       p1,
	output cpu_ctrl_pkg::seq_state_t seq,
	output logic [`CPU_IMM_W-1:0]    imm
);
	import cpu_ctrl_pkg::*;

	insn_u                 s0_q;
	insn_u                 s1_q;
	insn_u                 s0_next;
	logic                  v0_q;
	logic                  v1_q;
	logic                  fetch_ok;
	seq_state_t            seq_q;
	logic [`CPU_IMM_W-1:0] imm_q;
	logic [`CPU_IMM_W-1:0] imm_next;

	function automatic insn_class_t classify(input insn_u w);
		insn_class_t cls;
		case (w.word[15:12])
			4'h0:       cls = (w.word == `CPU_NOP_WORD) ? CLS_NOP : CLS_ILLEGAL; // 01xx etc dropped
			4'h1:       cls = CLS_IMM;
			4'h2:       cls = CLS_ALU2;
			4'h3:       cls = CLS_ALUI;
			4'h4:       cls = CLS_BR;
			4'h5:       cls = CLS_MEM;
			4'h8, 4'h9: cls = CLS_ALU3; // 3-bit prefix
			4'hc, 4'hd: cls = CLS_FLAGS; // 3-bit prefix
			default:    cls = CLS_ILLEGAL;
		endcase
		return cls;
	endfunction

	always_comb begin
		fetch_ok     = !seq_q.stall && !seq_q.delay && !req.feed_nop;
		s0_next.word = fetch_ok ? memory_in : `CPU_NOP_WORD; // otherwise inject NOP

		p0.valid = v0_q;
		p0.cls   = classify(s0_q);
		p0.insn  = s0_q;
		p1.valid = v1_q;
		p1.cls   = classify(s1_q);
		p1.insn  = s1_q;

		// prefix lives for exactly one following instruction
		if (p0.valid && p0.cls == CLS_IMM)
			imm_next = s0_q.word[`CPU_IMM_W-1:0];
		else
			imm_next = '0;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			s0_q.word   <= `CPU_NOP_WORD;
			s1_q.word   <= `CPU_NOP_WORD;
			v0_q        <= 1'b0;
			v1_q        <= 1'b0;
			seq_q.stall <= 1'b0;
			seq_q.delay <= 1'b0;
			imm_q       <= '0;
		end else begin
			s0_q        <= s0_next;
			s1_q        <= s0_q; // stage 1 always follows stage 0
			v0_q        <= fetch_ok;
			v1_q        <= v0_q;
			seq_q.stall <= req.stall_next;
			seq_q.delay <= req.delay_next;
			imm_q       <= imm_next;
		end
	end

	assign seq = seq_q;
	assign imm = imm_q;

	// a load never sits in a branch delay and vice versa
	a_stall_delay_excl: assert property (@(posedge CLK) disable iff (!RSTb)
		!(seq_q.stall && seq_q.delay))
		else $error("stall and delay set together");

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_cpu_ctrl -o sim_cpu_ctrl \
	&& ./obj_dir/sim_cpu_ctrl | tee /dev/stderr | grep -q "^Simulation passed$" \
	&& echo "run ok" \
	|| { echo "run failed"; exit 1; }

/* tb/cpu_ctrl_ref.svh */
/*
 * Reference model of the sequencing unit, included inside the testbench module.
 * Fields are cut from the raw word by bit position. Unused encodings act as NOP.
 * Needs ctrl_errs and pout_errs declared before the include.
 */
`ifndef CPU_CTRL_REF_SVH
`define CPU_CTRL_REF_SVH

logic [`CPU_WORD_W-1:0] m_s0; // stage words as the model sees them
logic [`CPU_WORD_W-1:0] m_s1;
logic                   m_v0; // word came from fetch
logic                   m_v1;
logic                   m_stall;
logic                   m_delay;
logic [`CPU_IMM_W-1:0]  m_imm;

// active-low mask with one register picked
function automatic logic [7:0] low_one(input logic [2:0] r);
	return ~(8'd1 << r);
endfunction

function automatic insn_class_t word_kind(input logic [15:0] w);
	insn_class_t k;
	case (w[15:12])
		4'h1:       k = CLS_IMM;
		4'h2:       k = CLS_ALU2;
		4'h3:       k = CLS_ALUI;
		4'h4:       k = CLS_BR;
		4'h5:       k = CLS_MEM;
		4'h8, 4'h9: k = CLS_ALU3;
		4'hc, 4'hd: k = CLS_FLAGS;
		default:    k = CLS_NOP; // nop and unused words do nothing
	endcase
	return k;
endfunction

function automatic logic cond_holds(input logic [2:0] cond, input logic cf, zf, sf);
	logic t;
	case (cond)
		3'd0:    t = zf;
		3'd1:    t = !zf;
		3'd2:    t = sf;
		3'd3:    t = !sf;
		3'd4:    t = cf;
		3'd5:    t = !cf;
		3'd6:    t = 1'b1;
		default: t = 1'b0; // cond 7 never taken
	endcase
	return t;
endfunction

task automatic reset_model();
	m_s0    = `CPU_NOP_WORD;
	m_s1    = `CPU_NOP_WORD;
	m_v0    = 1'b0;
	m_v1    = 1'b0;
	m_stall = 1'b0;
	m_delay = 1'b0;
	m_imm   = '0;
endtask

// state after the coming rising edge
task automatic advance_model(input logic [15:0] word_in, input logic cf, zf, sf,
	output logic fetched);
	logic taken;
	logic is_mem;
	taken   = m_v0 && word_kind(m_s0) == CLS_BR && cond_holds(m_s0[10:8], cf, zf, sf);
	is_mem  = m_v0 && word_kind(m_s0) == CLS_MEM;
	fetched = !m_stall && !m_delay && !taken && !is_mem;
	m_imm   = (m_v0 && word_kind(m_s0) == CLS_IMM) ? m_s0[11:0] : 12'h000;
	m_stall = is_mem && !m_s0[8]; // loads only
	m_delay = taken;
	m_s1    = m_s0;
	m_v1    = m_v0;
	m_s0    = fetched ? word_in : `CPU_NOP_WORD;
	m_v0    = fetched;
endtask

function automatic ctrl_word_t expected_ctrl(input logic cf, zf, sf);
	ctrl_word_t  e;
	logic [15:0] w;
	w                = m_s0;
	e                = '0;
	e.alu_b_from_p_b = 1'b1;
	e.ld_alu_b       = 8'hff;
	e.ld_mem_b       = 8'hff;
	e.ld_p_b         = 8'hff;
	e.inc_b          = 8'hff;
	e.dec_b          = 8'hff;
	e.m_en_b         = 1'b1;
	e.mem_oe_b       = 1'b1;
	e.mem_wr_b       = 1'b1;
	if (!m_stall) begin
		e.maddr_sel = `CPU_PC_REG; // fetch through r7
		e.mem_oe_b  = 1'b0;
		e.inc_b[7]  = 1'b0;
	end
	if (m_v0) begin
		case (word_kind(w))
			CLS_ALU2: begin
				e.alu_op    = {w[3], w[11:8]};
				e.alu_a_sel = w[6:4];
				e.alu_b_sel = w[2:0];
				if (!w[7])
					e.ld_alu_b = low_one(w[6:4]);
			end
			CLS_ALUI: begin
				e.alu_op         = {1'b0, w[11:8]};
				e.alu_a_sel      = w[6:4];
				e.alu_b_from_p_b = 1'b0;
				e.pout_lo        = w[3:0];
				if (!w[7])
					e.ld_alu_b = low_one(w[6:4]);
			end
			CLS_ALU3: begin
				e.alu_op    = {1'b0, w[12:9]};
				e.alu_a_sel = w[5:3];
				e.alu_b_sel = w[2:0];
				e.ld_alu_b  = low_one(w[8:6]);
			end
			CLS_BR: begin
				if (cond_holds(w[10:8], cf, zf, sf)) begin
					e.inc_b[7] = 1'b1;
					if (w[11]) begin // through the alu
						e.alu_op         = 5'd1;
						e.alu_a_sel      = w[6:4];
						e.alu_b_from_p_b = 1'b0;
						e.ld_alu_b       = low_one(`CPU_PC_REG);
					end else begin
						e.pout_lo = w[3:0];
						e.ld_p_b  = low_one(`CPU_PC_REG);
					end
				end
			end
			CLS_MEM: begin
				e.maddr_sel = w[2:0];
				if (w[8]) begin // store done here
					e.m_en_b         = 1'b0;
					e.m_sel          = w[6:4];
					e.mem_oe_b       = 1'b1;
					e.mem_wr_b       = 1'b0;
					e.inc_b[w[2:0]]  = w[9];
					e.dec_b[w[2:0]]  = w[10];
				end
				e.dec_b[7] = 1'b0; // pc steps back
				e.inc_b[7] = 1'b1;
			end
			CLS_FLAGS: begin
				e.pout_lo = {1'b0, cf, zf, sf};
				e.ld_p_b  = low_one(`CPU_FLAGS_REG);
			end
			default: ;
		endcase
	end
	if (m_v1 && word_kind(m_s1) == CLS_MEM && !m_s1[8]) begin // load read cycle
		e.maddr_sel          = m_s1[2:0];
		e.mem_oe_b           = 1'b0;
		e.mem_wr_b           = 1'b1;
		e.ld_mem_b           = low_one(m_s1[6:4]);
		e.inc_b[m_s1[2:0]]   = m_s1[9];
		e.dec_b[m_s1[2:0]]   = m_s1[10];
	end
	return e;
endfunction

task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp);
	if (got !== exp) begin
		ctrl_errs++;
		$display("CHECK FAILED @%0t: ctrl got %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_pout(input logic [`CPU_WORD_W-1:0] got, input logic [`CPU_WORD_W-1:0] exp);
	if (got !== exp) begin
		pout_errs++;
		$display("CHECK FAILED @%0t: pout got %h, expected %h", $time, got, exp);
	end
endtask

`endif

/* tb/tb_cpu_ctrl.sv */
/*
 * Testbench for cpu_ctrl_top. Words are offered on memory_in and taken
 * whenever the model says the next edge fetches; flags are random per cycle.
 * Outputs are compared at the falling edge, inputs change 1 ns after rising.
 */
`timescale 1ns/1ps
`include "cpu_ctrl_cfg.svh"

module tb_cpu_ctrl;
	import cpu_ctrl_pkg::*;

	logic                   CLK;
	logic                   RSTb;
	logic [`CPU_WORD_W-1:0] memory_in;
	logic                   c;
	logic                   z;
	logic                   s;
	ctrl_word_t             ctrl;
	logic [`CPU_WORD_W-1:0] pout;

	logic [15:0] prog[$]; // instruction stream
	int          pc_idx; // next word to offer
	int          cycles;
	int          cycle_limit;
	int          ctrl_errs;
	int          pout_errs;
	integer      seed;
	logic [31:0] flag_rnd;
	ctrl_word_t  exp_ctrl;
	logic        took;

	`include "cpu_ctrl_ref.svh"

	cpu_ctrl_top u_dut (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.memory_in (memory_in),
		.c         (c),
		.z         (z),
		.s         (s),
		.ctrl      (ctrl),
		.pout      (pout)
	);

	always #2 CLK = ~CLK;

	task automatic build_program();
		logic [31:0] r;
		logic [4:0]  k;
		for (k = 0; k < 5'd3; k++) begin // prefix, imm op, then plain op
			r = $random(seed);
			prog.push_back({4'h1, r[11:0]});
			prog.push_back({4'h3, r[15:12], r[16], r[19:17], r[23:20]});
			prog.push_back({4'h2, r[27:24], r[28], r[31:29], 4'h5});
		end
		for (k = 0; k < 5'd6; k++) begin
			r = $random(seed);
			prog.push_back({4'h2, r[11:0]});
			prog.push_back({4'h3, r[23:12]});
			prog.push_back({3'b100, r[31:19]});
		end
		for (k = 0; k < 5'd16; k++) begin // every cond, direct and indirect
			r = $random(seed);
			prog.push_back({4'h4, k[0], k[3:1], 1'b0, r[6:0]});
			prog.push_back({4'h4, !k[0], k[3:1], 1'b0, r[14:8]});
		end
		r = $random(seed);
		prog.push_back({4'h1, r[11:0]});
		prog.push_back({4'h4, 1'b0, 3'd6, 1'b0, r[18:12]}); // prefixed jump
		for (k = 0; k < 5'd10; k++) begin // stores and loads alternate
			r = $random(seed);
			prog.push_back({4'h5, 1'b0, r[10:9], k[0], 1'b0, r[6:4], 1'b0, r[2:0]});
		end
		for (k = 0; k < 5'd3; k++) begin
			r = $random(seed);
			prog.push_back({3'b110, r[12:0]});
		end
		prog.push_back(`CPU_NOP_WORD);
	endtask

	initial begin
		seed      = 80;
		CLK       = 1'b0;
		RSTb      = 1'b0;
		memory_in = `CPU_NOP_WORD;
		c         = 1'b0;
		z         = 1'b0;
		s         = 1'b0;
		pc_idx    = 0;
		cycles    = 0;
		ctrl_errs = 0;
		pout_errs = 0;
		build_program();
		cycle_limit = 2 * (3 * prog.size() + 10); // worst case 3 cycles a word
		repeat (4) @(posedge CLK);
		#1 RSTb = 1'b1;
		wait (pc_idx >= prog.size());
		repeat (4) @(posedge CLK); // drain both stages
		#1;
		$display("errors: ctrl %0d, pout %0d", ctrl_errs, pout_errs);
		if (ctrl_errs + pout_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// memory and flags, 1 ns after the edge
	always @(posedge CLK) begin
		#1;
		memory_in = (pc_idx < prog.size()) ? prog[pc_idx] : `CPU_NOP_WORD;
		flag_rnd  = $random(seed);
		c         = flag_rnd[0];
		z         = flag_rnd[1];
		s         = flag_rnd[2];
	end

	// compare, then step the model
	always @(negedge CLK) begin
		if (!RSTb) begin
			reset_model();
		end else begin
			exp_ctrl = expected_ctrl(c, z, s);
			check_ctrl(ctrl, exp_ctrl);
			check_pout(pout, {m_imm, exp_ctrl.pout_lo});
			advance_model(memory_in, c, z, s, took);
			if (took && pc_idx < prog.size())
				pc_idx++;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: program not finished after %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule
